/* verif/pipelineStimulus.txt */
// kind a b expA expB info; kind 1 = preload write (a = reg, b = value), 2 = instruction
// (a = instr, b = pc), 3 = write with next instr, 0 = end; info = rd<<8 | flags
1 00000001 00000014 00000000 00000000 00000000
1 00000002 00000007 00000000 00000000 00000000
1 00000003 fffffff0 00000000 00000000 00000000
1 00000004 00001000 00000000 00000000 00000000
1 00000005 0000abcd 00000000 00000000 00000000
2 00208333 00000000 0000001b 00000000 00000601
2 402083b3 00000004 0000000d 00000000 00000701
2 0030f433 00000008 00000010 00000000 00000801
2 005164b3 0000000c 0000abcf 00000000 00000901
2 0011a533 00000010 00000001 00000000 00000a01
2 ffb08593 00000014 0000000f 00000000 00000b01
2 0f02f613 00000018 000000c0 00000000 00000c01
2 10016693 0000001c 00000107 00000000 00000d01
2 fec1a713 00000020 00000000 00000000 00000e01
2 00508013 00000024 00000019 00000000 00000001
2 002007b3 00000028 00000007 00000000 00000f01
2 00822803 0000002c 00001008 00000000 00001005
2 002808b3 00000030 00000007 00000000 00001121
2 00522623 00000034 0000100c 0000abcd 00000002
2 00108863 00000038 00000048 00000000 00000010
2 00108913 0000003c 00000000 00000000 00000008
2 002089b3 00000040 00000000 00000000 00000008
2 00208863 00000044 00000000 00000000 00000000
2 00310a13 00000048 0000000a 00000000 00001401
2 000b0a93 0000004c 00000000 00000000 00001501
3 00000016 12345678 00000000 00000000 00000000
2 000b0b93 00000050 12345678 00000000 00001701
0 00000000 00000000 00000000 00000000 00000000

/* filelist.f */
common/rv32iPkg.sv
common/decodeBus.sv
design/decodeStage/instrDecoder.sv
design/decodeStage/regFile.sv
design/executeStage/executeUnit.sv
design/pipeReg.sv
design/hazardUnit.sv
design/pipelineTop.sv
verif/pipelineAssertions.sv
verif/pipelineTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module pipelineTb -o simv

output=$(./obj_dir/simv)
echo "$output"

if grep -q "all tests passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* verif/pipelineTb.sv */
// Testbench for the RV32I decode/execute/memory slice
// Stimulus file driver, output scoreboard, branch and stall checks

`timescale 1ns/1ps

module pipelineTb;
    import rv32iPkg::*;

    localparam int REC_W   = 6;
    localparam int MAX_REC = 32;

    logic                  clk;
    logic                  arstN;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc;
    logic                  wbEn;
    logic [REG_ADDR_W-1:0] wbAddr;
    logic [XLEN-1:0]       wbData;
    logic                  regWriteM;
    logic                  resultSrcM;
    logic                  memWriteM;
    logic [XLEN-1:0]       aluResultM;
    logic [XLEN-1:0]       rs2DataM;
    logic [REG_ADDR_W-1:0] rdM;
    logic                  pcSrc;
    logic [XLEN-1:0]       pcTarget;
    logic                  stallF;

    logic [31:0] stim [0:REC_W*MAX_REC-1];
    int          outQueue[$];
    int          edgeQueue[$];
    int          branchQueue[$];
    int          edgeCount;
    int          errors;
    int          tests;
    int          stallCycles;
    int          expStalls;
    logic        lastStall;

    pipelineTop u_dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) edgeCount++;

    function automatic logic [31:0] recordField(int rec, int k);
        return stim[rec*REC_W+k];
    endfunction

    task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input int rec, input int startErrors);
        tests++;
        $display("test %0d instr %h: %s", rec, recordField(rec, 1),
                 (errors == startErrors) ? "ok" : "error");
    endtask

    // Queue what the accepted instruction must produce
    task automatic acceptInstr(input int rec);
        logic [31:0] info;
        info = recordField(rec, 5);
        if (!info[3]) begin
            if (info[4]) begin
                branchQueue.push_back(rec);
            end
            if (info[0] || info[1]) begin
                outQueue.push_back(rec);
                edgeQueue.push_back(edgeCount + 2 + int'(info[5]));
            end
            expStalls += int'(info[5]);
        end
    endtask

    // Output monitor on the falling edge
    always @(negedge clk) begin
        int          rec;
        int          start;
        logic [31:0] info;
        if (arstN) begin
            if (stallF) begin
                stallCycles++;
                if (lastStall) begin
                    errors++;
                    $display("stallF stayed high for more than one cycle at %0t", $time);
                end
            end
            lastStall = stallF;
            if (pcSrc) begin
                if (branchQueue.size() == 0) begin
                    errors++;
                    $display("Unexpected taken branch at %0t", $time);
                end else begin
                    rec   = branchQueue.pop_front();
                    start = errors;
                    compareValue(pcTarget, recordField(rec, 3), "pcTarget");
                    reportTest(rec, start);
                end
            end
            if (regWriteM || memWriteM) begin
                if (outQueue.size() == 0) begin
                    errors++;
                    $display("Unexpected write at the outputs at %0t", $time);
                end else begin
                    rec   = outQueue.pop_front();
                    start = errors;
                    info  = recordField(rec, 5);
                    compareValue(32'(edgeCount), 32'(edgeQueue.pop_front()), "output edge");
                    compareValue(32'(regWriteM), 32'(info[0]), "regWriteM");
                    compareValue(32'(memWriteM), 32'(info[1]), "memWriteM");
                    compareValue(32'(resultSrcM), 32'(info[2]), "resultSrcM");
                    compareValue(aluResultM, recordField(rec, 3), "aluResultM");
                    if (info[0]) begin
                        compareValue(32'(rdM), 32'(info[12:8]), "rdM");
                    end
                    if (info[1]) begin
                        compareValue(rs2DataM, recordField(rec, 4), "rs2DataM");
                    end
                    reportTest(rec, start);
                end
            end
        end
    end

    initial begin
        int   idx;
        int   cur;
        int   steps;
        int   start;
        logic held;
        arstN       = 1'b0;
        instr       = '0;
        pc          = '0;
        wbEn        = 1'b0;
        wbAddr      = '0;
        wbData      = '0;
        edgeCount   = 0;
        errors      = 0;
        tests       = 0;
        stallCycles = 0;
        expStalls   = 0;
        lastStall   = 1'b0;
        $readmemh("verif/pipelineStimulus.txt", stim);

        repeat (4) @(posedge clk);
        #2 arstN = 1'b1;

        // Idle pipeline after reset
        @(negedge clk);
        start = errors;
        compareValue(32'(regWriteM), 32'd0, "regWriteM after reset");
        compareValue(32'(memWriteM), 32'd0, "memWriteM after reset");
        compareValue(32'(pcSrc), 32'd0, "pcSrc after reset");
        compareValue(32'(stallF), 32'd0, "stallF after reset");
        tests++;
        $display("test reset: %s", (errors == start) ? "ok" : "error");

        // Attempt to overwrite x0 through the test port
        @(posedge clk);
        #2;
        wbEn   = 1'b1;
        wbAddr = '0;
        wbData = 32'hffff_ffff;

        idx   = 0;
        cur   = -1;
        steps = 0;
        while ((recordField(idx, 0) != 32'd0 || cur >= 0) && steps < 500) begin
            @(negedge clk);
            held = stallF;
            @(posedge clk);
            #2;
            steps++;
            wbEn = 1'b0;
            if (!held) begin
                if (cur >= 0) begin
                    acceptInstr(cur);
                end
                cur   = -1;
                instr = '0;
                pc    = '0;
                if (recordField(idx, 0) == 32'd1) begin
                    wbEn   = 1'b1;
                    wbAddr = REG_ADDR_W'(recordField(idx, 1));
                    wbData = recordField(idx, 2);
                    idx++;
                end else begin
                    // Write in the same cycle as the next instruction
                    if (recordField(idx, 0) == 32'd3) begin
                        wbEn   = 1'b1;
                        wbAddr = REG_ADDR_W'(recordField(idx, 1));
                        wbData = recordField(idx, 2);
                        idx++;
                    end
                    if (recordField(idx, 0) == 32'd2) begin
                        cur   = idx;
                        instr = recordField(idx, 1);
                        pc    = recordField(idx, 2);
                        idx++;
                    end
                end
            end
        end
        if (steps >= 500) begin
            errors++;
            $display("Timeout while driving the instruction stream");
        end

        steps = 0;
        while ((outQueue.size() != 0 || branchQueue.size() != 0) && steps < 20) begin
            @(negedge clk);
            steps++;
        end
        if (outQueue.size() != 0 || branchQueue.size() != 0) begin
            errors++;
            $display("Timeout waiting for %0d results", outQueue.size() + branchQueue.size());
        end
        // Catch any stray write after the last result
        repeat (4) @(negedge clk);

        start = errors;
        compareValue(32'(stallCycles), 32'(expStalls), "stall cycle count");
        tests++;
        $display("test load-use stall count: %s", (errors == start) ? "ok" : "error");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verif/pipelineAssertions.sv */
// Concurrent checks on the pipeline slice outputs
// Reset quiet, write exclusivity, squash after a taken branch

`timescale 1ns/1ps

module pipelineAssertions (
    input logic clk,
    input logic arstN,
    input logic regWriteM,
    input logic memWriteM,
    input logic resultSrcM,
    input logic pcSrc,
    input logic stallF
);

    resetQuiet: assert property (@(posedge clk)
        !arstN |-> (!regWriteM && !memWriteM && !resultSrcM && !pcSrc && !stallF))
        else $error("outputs active during reset");

    writeExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(regWriteM && memWriteM))
        else $error("regWriteM and memWriteM high together");

    // Younger instructions of a taken beq never write
    branchSquash: assert property (@(posedge clk) disable iff (!arstN)
        pcSrc |-> ##2 (!regWriteM && !memWriteM))
        else $error("squashed instruction reached the memory stage");

endmodule

bind pipelineTop pipelineAssertions u_assertions (
    .clk        (clk),
    .arstN      (arstN),
    .regWriteM  (regWriteM),
    .memWriteM  (memWriteM),
    .resultSrcM (resultSrcM),
    .pcSrc      (pcSrc),
    .stallF     (stallF)
);

/* design/pipelineTop.sv */
// Decode, execute and memory-register slice of an RV32I pipeline
// Stage registers, decoder, register file, ALU and hazard unit

`timescale 1ns/1ps

module pipelineTop (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic [rv32iPkg::XLEN-1:0]         instr,
    input  logic [rv32iPkg::XLEN-1:0]         pc,
    // Test write port into the register file
    input  logic                              wbEn,
    input  logic [rv32iPkg::REG_ADDR_W-1:0]   wbAddr,
    input  logic [rv32iPkg::XLEN-1:0]         wbData,
    output logic                              regWriteM,
    output logic                              resultSrcM,
    output logic                              memWriteM,
    output logic [rv32iPkg::XLEN-1:0]         aluResultM,
    output logic [rv32iPkg::XLEN-1:0]         rs2DataM,
    output logic [rv32iPkg::REG_ADDR_W-1:0]   rdM,
    output logic                              pcSrc,
    output logic [rv32iPkg::XLEN-1:0]         pcTarget,
    output logic                              stallF
);
    import rv32iPkg::*;

    fetchPayloadT fetchIn;
    fetchPayloadT decodeQ;
    decExPayloadT decodeOut;
    decExPayloadT executeQ;
    exMemPayloadT executeOut;
    exMemPayloadT memoryQ;

    logic [XLEN-1:0] aluResultE;
    logic            stallD;
    logic            flushD;
    logic            flushE;

    decodeBus decBus ();

    assign fetchIn = '{instr: instr, pc: pc};

    pipeReg #(.payloadT(fetchPayloadT)) u_fetchDecodeReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (stallD),
        .flush (flushD),
        .d     (fetchIn),
        .q     (decodeQ)
    );

    instrDecoder u_instrDecoder (
        .bus   (decBus.decoder),
        .instr (decodeQ.instr)
    );

    regFile u_regFile (
        .clk    (clk),
        .arstN  (arstN),
        .bus    (decBus.regRead),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    assign decodeOut = '{ctrl: decBus.ctrl, rs1Data: decBus.rs1Data,
                         rs2Data: decBus.rs2Data, imm: decBus.imm,
                         pc: decodeQ.pc, rd: decBus.rd};

    pipeReg #(.payloadT(decExPayloadT)) u_decodeExecuteReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (1'b0),
        .flush (flushE),
        .d     (decodeOut),
        .q     (executeQ)
    );

    executeUnit u_executeUnit (
        .payload   (executeQ),
        .aluResult (aluResultE),
        .pcSrc     (pcSrc),
        .pcTarget  (pcTarget)
    );

    assign executeOut = '{regWrite: executeQ.ctrl.regWrite,
                          resultSrc: executeQ.ctrl.resultSrc,
                          memWrite: executeQ.ctrl.memWrite,
                          aluResult: aluResultE,
                          rs2Data: executeQ.rs2Data,
                          rd: executeQ.rd};

    pipeReg #(.payloadT(exMemPayloadT)) u_executeMemoryReg (
        .clk   (clk),
        .arstN (arstN),
        .stall (1'b0),
        .flush (1'b0),
        .d     (executeOut),
        .q     (memoryQ)
    );

    hazardUnit u_hazardUnit (
        .bus     (decBus.hazard),
        .execute (executeQ),
        .pcSrc   (pcSrc),
        .stallF  (stallF),
        .stallD  (stallD),
        .flushD  (flushD),
        .flushE  (flushE)
    );

    assign regWriteM  = memoryQ.regWrite;
    assign resultSrcM = memoryQ.resultSrc;
    assign memWriteM  = memoryQ.memWrite;
    assign aluResultM = memoryQ.aluResult;
    assign rs2DataM   = memoryQ.rs2Data;
    assign rdM        = memoryQ.rd;

endmodule

/* design/hazardUnit.sv */
// Hazard unit: load-use stall detection and branch flush

`timescale 1ns/1ps

module hazardUnit (
    decodeBus.hazard                bus,
    input  rv32iPkg::decExPayloadT  execute,
    input  logic                    pcSrc,
    output logic                    stallF,
    output logic                    stallD,
    output logic                    flushD,
    output logic                    flushE
);
    import rv32iPkg::*;

    logic rdMatch;
    logic loadUse;

    // Load in execute whose rd feeds the instruction in decode
    assign rdMatch = (execute.rd == bus.rs1) || (execute.rd == bus.rs2);
    assign loadUse = execute.ctrl.resultSrc && (execute.rd != '0) && rdMatch;

    // Hold fetch and decode for one cycle
    assign stallF = loadUse;
    assign stallD = loadUse;

    // Taken branch squashes the two younger instructions
    assign flushD = pcSrc;
    // Bubble into execute for a stall or a taken branch
    assign flushE = loadUse | pcSrc;

endmodule

/* design/pipeReg.sv */
// Generic stage register with stall hold and flush to bubble

`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Flush has priority over stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* design/executeStage/executeUnit.sv */
// Execute stage: operand B select, ALU with zero flag
// Branch target and beq taken decision

`timescale 1ns/1ps

module executeUnit (
    input  rv32iPkg::decExPayloadT        payload,
    output logic [rv32iPkg::XLEN-1:0]     aluResult,
    output logic                          pcSrc,
    output logic [rv32iPkg::XLEN-1:0]     pcTarget
);
    import rv32iPkg::*;

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic            zero;

    assign srcA = payload.rs1Data;
    assign srcB = payload.ctrl.aluSrc ? payload.imm : payload.rs2Data;

    always_comb begin
        case (payload.ctrl.aluOp)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            // Signed compare
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq taken when the subtraction is zero
    assign pcSrc    = payload.ctrl.branch & zero;
    assign pcTarget = payload.pc + payload.imm;

endmodule

/* design/decodeStage/regFile.sv */
// 32x32 register file, two combinational reads, one test write port
// x0 reads zero and ignores writes

`timescale 1ns/1ps

module regFile (
    input  logic                              clk,
    input  logic                              arstN,
    decodeBus.regRead                         bus,
    input  logic                              wbEn,
    input  logic [rv32iPkg::REG_ADDR_W-1:0]   wbAddr,
    input  logic [rv32iPkg::XLEN-1:0]         wbData
);
    import rv32iPkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Same-cycle read sees the value before the write edge
    assign bus.rs1Data = (bus.rs1 == '0) ? '0 : regs[bus.rs1];
    assign bus.rs2Data = (bus.rs2 == '0) ? '0 : regs[bus.rs2];

endmodule

/* design/decodeStage/instrDecoder.sv */
// Instruction decoder: register fields, control word, immediate
// Covers R-type, I-type ALU, lw, sw and beq

`timescale 1ns/1ps

module instrDecoder (
    decodeBus.decoder                  bus,
    input  logic [rv32iPkg::XLEN-1:0]  instr
);
    import rv32iPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    immSrcT     immSrc;
    ctrlT       ctrl;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    assign bus.rd  = instr[11:7];
    assign bus.rs1 = instr[19:15];
    assign bus.rs2 = instr[24:20];

    always_comb begin
        ctrl   = '0;
        immSrc = IMM_I;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    F3_ADD:  ctrl.aluOp = funct7b5 ? ALU_SUB : ALU_ADD;
                    F3_AND:  ctrl.aluOp = ALU_AND;
                    F3_OR:   ctrl.aluOp = ALU_OR;
                    F3_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl       = '0;
                endcase
            end
            OP_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                case (funct3)
                    F3_ADD:  ctrl.aluOp = ALU_ADD;
                    F3_AND:  ctrl.aluOp = ALU_AND;
                    F3_OR:   ctrl.aluOp = ALU_OR;
                    F3_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl       = '0;
                endcase
            end
            OP_LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.resultSrc = 1'b1;
                    ctrl.aluSrc    = 1'b1;
                    ctrl.aluOp     = ALU_ADD;
                end
            end
            OP_STORE: begin
                immSrc = IMM_S;
                if (funct3 == F3_WORD) begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluOp    = ALU_ADD;
                end
            end
            OP_BRANCH: begin
                immSrc = IMM_B;
                // beq compares by subtraction
                if (funct3 == F3_BEQ) begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = ALU_SUB;
                end
            end
            default: ctrl = '0;
        endcase
    end

    assign bus.ctrl = ctrl;

    // Sign-extended immediate
    always_comb begin
        case (immSrc)
            IMM_S:   bus.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   bus.imm = {{19{instr[31]}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};
            default: bus.imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

/* common/decodeBus.sv */
// Decode-stage bus: decoder outputs and register file read ports
// Modports for decoder, register file and hazard unit

`timescale 1ns/1ps

interface decodeBus;
    import rv32iPkg::*;

    ctrlT                  ctrl;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1Data;
    logic [XLEN-1:0]       rs2Data;

    modport decoder (
        output ctrl, imm, rd, rs1, rs2
    );

    modport regRead (
        input  rs1, rs2,
        output rs1Data, rs2Data
    );

    // Source registers only, for load-use checks
    modport hazard (
        input rs1, rs2
    );

endinterface

/* common/rv32iPkg.sv */
// Widths, opcode and funct3 constants for the RV32I slice
// ALU and immediate enums, control struct, stage payload structs

package rv32iPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 codes of the supported subset
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2
    } immSrcT;

    // All-zero value is the bubble
    typedef struct packed {
        logic  regWrite;
        logic  resultSrc;
        logic  memWrite;
        logic  branch;
        logic  aluSrc;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
    } fetchPayloadT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [XLEN-1:0]       rs1Data;
        logic [XLEN-1:0]       rs2Data;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
    } decExPayloadT;

    typedef struct packed {
        logic                  regWrite;
        logic                  resultSrc;
        logic                  memWrite;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       rs2Data;
        logic [REG_ADDR_W-1:0] rd;
    } exMemPayloadT;

endpackage
